/* verilog.f */
rtl/gpr_pkg.sv
rtl/gpr_bank_tp.sv
rtl/gpr_bank_dp.sv
rtl/gpr_operand_collect.sv
rtl/gpr_stage.sv
sim/gpr_tb.sv

/* Makefile */
TOP := gpr_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q -F '*** PASSED ***' sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir sim.log

/* sim/gpr_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module gpr_tb;

    localparam int unsigned CLK_PERIOD_NS = 40;
    localparam int unsigned DIRECTED_OPS  = 300;
    localparam int unsigned RAND_OPS      = 400;
    localparam int unsigned STALL_PCT     = 40;
    localparam int unsigned WATCHDOG_NS   = (DIRECTED_OPS + RAND_OPS * 8) * CLK_PERIOD_NS;

    logic                              clk_i;
    logic                              rst_n_i;
    logic                              wb_valid_i;
    logic [gpr_pkg::WID_W-1:0]         wb_wid_i;
    logic [gpr_pkg::REG_W-1:0]         wb_rd_i;
    logic [gpr_pkg::NUM_THREADS-1:0]   wb_tmask_i;
    logic [gpr_pkg::LANES_W-1:0]       wb_data_i;
    logic                              wb_ready_o;
    logic                              req_valid_i;
    logic [gpr_pkg::WID_W-1:0]         req_wid_i;
    logic [gpr_pkg::REG_W-1:0]         req_rs1_i;
    logic [gpr_pkg::REG_W-1:0]         req_rs2_i;
    logic [gpr_pkg::REG_W-1:0]         req_rs3_i;
    logic                              req_ready_o;
    logic                              rsp_valid_o;
    logic [gpr_pkg::LANES_W-1:0]       rsp_rs1_data_o;
    logic [gpr_pkg::LANES_W-1:0]       rsp_rs2_data_o;
    logic [gpr_pkg::LANES_W-1:0]       rsp_rs3_data_o;
    logic                              rsp_ready_i;

    // Shadow register file with one word per warp, register and lane
    logic [gpr_pkg::XLEN-1:0] shadow [gpr_pkg::NUM_WARPS][gpr_pkg::NUM_REGS][gpr_pkg::NUM_THREADS];

    logic [gpr_pkg::LANES_W-1:0] exp_rs1_q [$];
    logic [gpr_pkg::LANES_W-1:0] exp_rs2_q [$];
    logic [gpr_pkg::LANES_W-1:0] exp_rs3_q [$];
    string                       name_q [$];
    string                       test_name;
    logic                        exp_valid = 1'b0;

    gpr_stage dut_i (.*);

    always #(CLK_PERIOD_NS / 2) clk_i = ~clk_i;

    ////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////

    function automatic logic [gpr_pkg::REG_W-1:0] rand_reg(input int unsigned hi);
        int unsigned r;
        r = $urandom_range(hi, 0);
        return r[gpr_pkg::REG_W-1:0];
    endfunction

    function automatic logic [gpr_pkg::WID_W-1:0] rand_wid();
        int unsigned r;
        r = $urandom;
        return r[gpr_pkg::WID_W-1:0];
    endfunction

    function automatic logic [gpr_pkg::NUM_THREADS-1:0] rand_mask();
        int unsigned r;
        r = $urandom;
        return r[gpr_pkg::NUM_THREADS-1:0];
    endfunction

    function automatic logic [gpr_pkg::LANES_W-1:0] rand_lanes();
        logic [gpr_pkg::LANES_W-1:0] d;
        for (int i = 0; i < gpr_pkg::NUM_THREADS; i++) begin
            d[i*gpr_pkg::XLEN +: gpr_pkg::XLEN] = $urandom;
        end
        return d;
    endfunction

    // Every lane word carries salt, warp, register and lane
    function automatic logic [gpr_pkg::LANES_W-1:0] make_data(input int w, input int r,
                                                               input int salt);
        logic [gpr_pkg::LANES_W-1:0] d;
        for (int i = 0; i < gpr_pkg::NUM_THREADS; i++) begin
            d[i*gpr_pkg::XLEN +: gpr_pkg::XLEN] = (salt << 24) | (w << 16) | (r << 8) | i;
        end
        return d;
    endfunction

    function automatic logic [gpr_pkg::LANES_W-1:0] ref_operand(
        input logic [gpr_pkg::WID_W-1:0] wid,
        input logic [gpr_pkg::REG_W-1:0] rg
    );
        logic [gpr_pkg::LANES_W-1:0] res;
        res = '0;
        if (rg != '0) begin
            for (int i = 0; i < gpr_pkg::NUM_THREADS; i++) begin
                res[i*gpr_pkg::XLEN +: gpr_pkg::XLEN] = shadow[wid][rg][i];
            end
        end
        return res;
    endfunction

    task automatic report_failure();
        $display("*** FAILED ***");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string what, input logic [gpr_pkg::LANES_W-1:0] exp_val,
                               input logic [gpr_pkg::LANES_W-1:0] act_val);
        assert (act_val === exp_val) else begin
            $display("mismatch %s %s: expected %h actual %h", name_q[0], what, exp_val, act_val);
            report_failure();
        end
    endtask

    // Write lasts one cycle and the read is held until accepted
    task automatic drive_op(input bit do_wr, input int wid, input int rd, input int mask,
                            input logic [gpr_pkg::LANES_W-1:0] data, input bit do_rd,
                            input int rwid, input int rs1, input int rs2, input int rs3);
        logic acc;
        wb_valid_i  = do_wr;
        wb_wid_i    = wid[gpr_pkg::WID_W-1:0];
        wb_rd_i     = rd[gpr_pkg::REG_W-1:0];
        wb_tmask_i  = mask[gpr_pkg::NUM_THREADS-1:0];
        wb_data_i   = data;
        req_valid_i = do_rd;
        req_wid_i   = rwid[gpr_pkg::WID_W-1:0];
        req_rs1_i   = rs1[gpr_pkg::REG_W-1:0];
        req_rs2_i   = rs2[gpr_pkg::REG_W-1:0];
        req_rs3_i   = rs3[gpr_pkg::REG_W-1:0];
        acc = 1'b0;
        while (!acc) begin
            @(posedge clk_i);
            acc = !req_valid_i || req_ready_o;
            @(negedge clk_i);
            wb_valid_i = 1'b0;
        end
        req_valid_i = 1'b0;
    endtask

    task automatic write_reg(input int wid, input int rd, input int mask,
                             input logic [gpr_pkg::LANES_W-1:0] data);
        drive_op(1'b1, wid, rd, mask, data, 1'b0, 0, 0, 0, 0);
    endtask

    task automatic read_regs(input int wid, input int rs1, input int rs2, input int rs3);
        drive_op(1'b0, 0, 0, 0, '0, 1'b1, wid, rs1, rs2, rs3);
    endtask

    // A pending request is accepted on the first edge with ready high
    task automatic drain();
        rsp_ready_i = 1'b1;
        wb_valid_i  = 1'b0;
        @(posedge clk_i);
        @(negedge clk_i);
        req_valid_i = 1'b0;
        while (exp_rs1_q.size() != 0) begin
            @(negedge clk_i);
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // Reference update and response check
    ////////////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin : monitor
        logic acc;
        if (rst_n_i) begin
            assert (wb_ready_o === 1'b1) else begin
                $display("mismatch %s wb_ready: expected 1 actual %b", test_name, wb_ready_o);
                report_failure();
            end
            assert (rsp_valid_o === exp_valid && req_ready_o === (!exp_valid || rsp_ready_i))
            else begin
                $display("mismatch %s handshake: expected valid/ready %b/%b actual %b/%b",
                         test_name, exp_valid, !exp_valid || rsp_ready_i, rsp_valid_o, req_ready_o);
                report_failure();
            end
            if (rsp_valid_o) begin
                check_value("rs1", exp_rs1_q[0], rsp_rs1_data_o);
                check_value("rs2", exp_rs2_q[0], rsp_rs2_data_o);
                check_value("rs3", exp_rs3_q[0], rsp_rs3_data_o);
                if (rsp_ready_i) begin
                    void'(exp_rs1_q.pop_front());
                    void'(exp_rs2_q.pop_front());
                    void'(exp_rs3_q.pop_front());
                    void'(name_q.pop_front());
                end
            end
            // Write first, so a same-edge read sees it
            if (wb_valid_i && wb_rd_i != '0) begin
                for (int i = 0; i < gpr_pkg::NUM_THREADS; i++) begin
                    if (wb_tmask_i[i]) begin
                        shadow[wb_wid_i][wb_rd_i][i] = wb_data_i[i*gpr_pkg::XLEN +: gpr_pkg::XLEN];
                    end
                end
            end
            acc = req_valid_i && req_ready_o;
            if (acc) begin
                exp_rs1_q.push_back(ref_operand(req_wid_i, req_rs1_i));
                exp_rs2_q.push_back(ref_operand(req_wid_i, req_rs2_i));
                exp_rs3_q.push_back(ref_operand(req_wid_i, req_rs3_i));
                name_q.push_back(test_name);
            end
            exp_valid = acc || (exp_valid && !rsp_ready_i);
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, not all responses came back", WATCHDOG_NS);
        report_failure();
    end

    ////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        logic acc;
        void'($urandom(32'h444e));
        clk_i       = 1'b0;
        rst_n_i     = 1'b0;
        wb_valid_i  = 1'b0;
        wb_wid_i    = '0;
        wb_rd_i     = '0;
        wb_tmask_i  = '0;
        wb_data_i   = '0;
        req_valid_i = 1'b0;
        req_wid_i   = '0;
        req_rs1_i   = '0;
        req_rs2_i   = '0;
        req_rs3_i   = '0;
        rsp_ready_i = 1'b1;
        test_name   = "reset";
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        test_name = "fill_readback";
        for (int w = 0; w < gpr_pkg::NUM_WARPS; w++) begin
            for (int r = 1; r < 8; r++) begin
                write_reg(w, r, 15, make_data(w, r, 0));
            end
        end
        for (int w = 0; w < gpr_pkg::NUM_WARPS; w++) begin
            for (int r = 1; r < 8; r++) begin
                read_regs(w, r, 8 - r, ((r + 2) % 7) + 1);
            end
        end
        drain();

        test_name = "partial_mask";
        for (int w = 0; w < gpr_pkg::NUM_WARPS; w++) begin
            write_reg(w, 3, 5, make_data(w, 3, 1));
            write_reg(w, 5, 10, make_data(w, 5, 2));
            read_regs(w, 3, 5, 3);
        end
        drain();

        test_name = "r0_zero";
        for (int w = 0; w < gpr_pkg::NUM_WARPS; w++) begin
            write_reg(w, 0, 15, make_data(w, 0, 3));
            read_regs(w, 0, 0, 0);
            read_regs(w, 0, 1, 0);
        end
        drain();

        test_name = "same_cycle_forward";
        drive_op(1'b1, 1, 2, 6, make_data(1, 2, 4), 1'b1, 1, 2, 6, 2);
        drive_op(1'b1, 1, 2, 9, make_data(1, 2, 5), 1'b1, 2, 2, 2, 2);
        drive_op(1'b1, 3, 7, 15, make_data(3, 7, 6), 1'b1, 3, 7, 7, 7);
        drain();

        test_name = "back_to_back";
        for (int n = 0; n < 16; n++) begin
            req_valid_i = 1'b1;
            req_wid_i   = rand_wid();
            req_rs1_i   = rand_reg(7);
            req_rs2_i   = rand_reg(7);
            req_rs3_i   = rand_reg(7);
            @(posedge clk_i);
            assert (req_ready_o) else begin
                $display("req_ready_o dropped during back-to-back requests");
                report_failure();
            end
            @(negedge clk_i);
        end
        req_valid_i = 1'b0;
        drain();

        // Narrow register range so writes often hit stalled reads
        test_name = "random_stall";
        for (int n = 0; n < RAND_OPS; n++) begin
            wb_valid_i  = ($urandom_range(1, 0) == 1);
            wb_wid_i    = rand_wid();
            wb_rd_i     = rand_reg(7);
            wb_tmask_i  = rand_mask();
            wb_data_i   = rand_lanes();
            rsp_ready_i = ($urandom_range(99, 0) >= STALL_PCT);
            if (!req_valid_i && $urandom_range(3, 0) != 0) begin
                req_valid_i = 1'b1;
                req_wid_i   = rand_wid();
                req_rs1_i   = rand_reg(7);
                req_rs2_i   = rand_reg(7);
                req_rs3_i   = rand_reg(7);
            end
            @(posedge clk_i);
            acc = req_valid_i && req_ready_o;
            @(negedge clk_i);
            if (acc) begin
                req_valid_i = 1'b0;
            end
        end
        drain();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/gpr_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module gpr_stage (
    input  wire logic                              clk_i,
    input  wire logic                              rst_n_i,

    input  wire logic                              wb_valid_i,
    input  wire logic [gpr_pkg::WID_W-1:0]         wb_wid_i,
    input  wire logic [gpr_pkg::REG_W-1:0]         wb_rd_i,
    input  wire logic [gpr_pkg::NUM_THREADS-1:0]   wb_tmask_i,
    input  wire logic [gpr_pkg::LANES_W-1:0]       wb_data_i,
    output logic                                   wb_ready_o,

    input  wire logic                              req_valid_i,
    input  wire logic [gpr_pkg::WID_W-1:0]         req_wid_i,
    input  wire logic [gpr_pkg::REG_W-1:0]         req_rs1_i,
    input  wire logic [gpr_pkg::REG_W-1:0]         req_rs2_i,
    input  wire logic [gpr_pkg::REG_W-1:0]         req_rs3_i,
    output logic                                   req_ready_o,

    output logic                                   rsp_valid_o,
    output logic      [gpr_pkg::LANES_W-1:0]       rsp_rs1_data_o,
    output logic      [gpr_pkg::LANES_W-1:0]       rsp_rs2_data_o,
    output logic      [gpr_pkg::LANES_W-1:0]       rsp_rs3_data_o,
    input  wire logic                              rsp_ready_i
);

    logic [gpr_pkg::NUM_THREADS-1:0] wr_en;
    logic [gpr_pkg::RAM_AW-1:0]      wr_addr;
    logic [gpr_pkg::LANES_W-1:0]     wr_data;
    logic                            rd_en;
    logic [gpr_pkg::RAM_AW-1:0]      rd_addr1;
    logic [gpr_pkg::RAM_AW-1:0]      rd_addr2;
    logic [gpr_pkg::RAM_AW-1:0]      rd_addr3;
    logic [gpr_pkg::LANES_W-1:0]     rs1_q;
    logic [gpr_pkg::LANES_W-1:0]     rs2_q;
    logic [gpr_pkg::LANES_W-1:0]     rs3_q;

    gpr_operand_collect collect_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .wb_valid_i     (wb_valid_i),
        .wb_wid_i       (wb_wid_i),
        .wb_rd_i        (wb_rd_i),
        .wb_tmask_i     (wb_tmask_i),
        .wb_data_i      (wb_data_i),
        .wb_ready_o     (wb_ready_o),
        .req_valid_i    (req_valid_i),
        .req_wid_i      (req_wid_i),
        .req_rs1_i      (req_rs1_i),
        .req_rs2_i      (req_rs2_i),
        .req_rs3_i      (req_rs3_i),
        .req_ready_o    (req_ready_o),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_rs1_data_o (rsp_rs1_data_o),
        .rsp_rs2_data_o (rsp_rs2_data_o),
        .rsp_rs3_data_o (rsp_rs3_data_o),
        .rsp_ready_i    (rsp_ready_i),
        .wr_en_o        (wr_en),
        .wr_addr_o      (wr_addr),
        .wr_data_o      (wr_data),
        .rd_en_o        (rd_en),
        .rd_addr1_o     (rd_addr1),
        .rd_addr2_o     (rd_addr2),
        .rd_addr3_o     (rd_addr3),
        .rs1_q_i        (rs1_q),
        .rs2_q_i        (rs2_q),
        .rs3_q_i        (rs3_q)
    );

    // rs1 and rs2 storage
    gpr_bank_tp bank_tp_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .wr_en_i    (wr_en),
        .wr_addr_i  (wr_addr),
        .wr_data_i  (wr_data),
        .rd_en_i    (rd_en),
        .rd_addr1_i (rd_addr1),
        .rd_addr2_i (rd_addr2),
        .rd_data1_o (rs1_q),
        .rd_data2_o (rs2_q)
    );

    // rs3 storage, same writes
    gpr_bank_dp bank_dp_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr3),
        .rd_data_o (rs3_q)
    );

endmodule

`default_nettype wire

/* rtl/gpr_operand_collect.sv */
`timescale 1ns/1ps
`default_nettype none

module gpr_operand_collect (
    input  wire logic                              clk_i,
    input  wire logic                              rst_n_i,

    // Writeback channel
    input  wire logic                              wb_valid_i,
    input  wire logic [gpr_pkg::WID_W-1:0]         wb_wid_i,
    input  wire logic [gpr_pkg::REG_W-1:0]         wb_rd_i,
    input  wire logic [gpr_pkg::NUM_THREADS-1:0]   wb_tmask_i,
    input  wire logic [gpr_pkg::LANES_W-1:0]       wb_data_i,
    output logic                                   wb_ready_o,

    // Request channel
    input  wire logic                              req_valid_i,
    input  wire logic [gpr_pkg::WID_W-1:0]         req_wid_i,
    input  wire logic [gpr_pkg::REG_W-1:0]         req_rs1_i,
    input  wire logic [gpr_pkg::REG_W-1:0]         req_rs2_i,
    input  wire logic [gpr_pkg::REG_W-1:0]         req_rs3_i,
    output logic                                   req_ready_o,

    // Response channel
    output logic                                   rsp_valid_o,
    output logic      [gpr_pkg::LANES_W-1:0]       rsp_rs1_data_o,
    output logic      [gpr_pkg::LANES_W-1:0]       rsp_rs2_data_o,
    output logic      [gpr_pkg::LANES_W-1:0]       rsp_rs3_data_o,
    input  wire logic                              rsp_ready_i,

    // Bank side
    output logic      [gpr_pkg::NUM_THREADS-1:0]   wr_en_o,
    output logic      [gpr_pkg::RAM_AW-1:0]        wr_addr_o,
    output logic      [gpr_pkg::LANES_W-1:0]       wr_data_o,
    output logic                                   rd_en_o,
    output logic      [gpr_pkg::RAM_AW-1:0]        rd_addr1_o,
    output logic      [gpr_pkg::RAM_AW-1:0]        rd_addr2_o,
    output logic      [gpr_pkg::RAM_AW-1:0]        rd_addr3_o,
    input  wire logic [gpr_pkg::LANES_W-1:0]       rs1_q_i,
    input  wire logic [gpr_pkg::LANES_W-1:0]       rs2_q_i,
    input  wire logic [gpr_pkg::LANES_W-1:0]       rs3_q_i
);

    //////////////////////////////////////////////////////////////////////
    // Write side
    //////////////////////////////////////////////////////////////////////

    logic wr_valid;

    // r0 is hardwired, drop any write to it
    assign wr_valid = wb_valid_i && (wb_rd_i != '0);

    assign wr_en_o    = wr_valid ? wb_tmask_i : '0;
    assign wr_addr_o  = {wb_wid_i, wb_rd_i};
    assign wr_data_o  = wb_data_i;
    assign wb_ready_o = 1'b1;

    //////////////////////////////////////////////////////////////////////
    // Read issue
    //////////////////////////////////////////////////////////////////////

    logic req_accept;

    assign req_ready_o = !rsp_valid_o || rsp_ready_i;
    assign req_accept  = req_valid_i && req_ready_o;

    assign rd_en_o    = req_accept;
    assign rd_addr1_o = {req_wid_i, req_rs1_i};
    assign rd_addr2_o = {req_wid_i, req_rs2_i};
    assign rd_addr3_o = {req_wid_i, req_rs3_i};

    // Same-edge write hits on each operand
    logic fwd1_hit;
    logic fwd2_hit;
    logic fwd3_hit;

    assign fwd1_hit = wr_valid && (wb_wid_i == req_wid_i) && (wb_rd_i == req_rs1_i);
    assign fwd2_hit = wr_valid && (wb_wid_i == req_wid_i) && (wb_rd_i == req_rs2_i);
    assign fwd3_hit = wr_valid && (wb_wid_i == req_wid_i) && (wb_rd_i == req_rs3_i);

    logic                            rsp_valid_q;
    logic                            zero1_q;
    logic                            zero2_q;
    logic                            zero3_q;
    logic                            fwd1_q;
    logic                            fwd2_q;
    logic                            fwd3_q;
    logic [gpr_pkg::NUM_THREADS-1:0] fwd_mask_q;
    logic [gpr_pkg::LANES_W-1:0]     fwd_data_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
            zero1_q     <= 1'b0;
            zero2_q     <= 1'b0;
            zero3_q     <= 1'b0;
            fwd1_q      <= 1'b0;
            fwd2_q      <= 1'b0;
            fwd3_q      <= 1'b0;
        end else if (req_accept) begin
            rsp_valid_q <= 1'b1;
            zero1_q     <= (req_rs1_i == '0);
            zero2_q     <= (req_rs2_i == '0);
            zero3_q     <= (req_rs3_i == '0);
            fwd1_q      <= fwd1_hit;
            fwd2_q      <= fwd2_hit;
            fwd3_q      <= fwd3_hit;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    // Write payload, shared by the three operands
    always_ff @(posedge clk_i) begin
        if (req_accept) begin
            fwd_mask_q <= wb_tmask_i;
            fwd_data_q <= wb_data_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output merge
    //////////////////////////////////////////////////////////////////////

    // Everything feeding this is frozen until the next accept
    function automatic logic [gpr_pkg::LANES_W-1:0] merge_lanes(
        input logic                            zero,
        input logic                            fwd,
        input logic [gpr_pkg::NUM_THREADS-1:0] mask,
        input logic [gpr_pkg::LANES_W-1:0]     fwd_data,
        input logic [gpr_pkg::LANES_W-1:0]     bank_q
    );
        logic [gpr_pkg::LANES_W-1:0] res;
        res = bank_q;
        for (int i = 0; i < gpr_pkg::NUM_THREADS; i++) begin
            if (fwd && mask[i]) begin
                res[i*gpr_pkg::XLEN +: gpr_pkg::XLEN] =
                    fwd_data[i*gpr_pkg::XLEN +: gpr_pkg::XLEN];
            end
        end
        if (zero) begin
            res = '0;
        end
        return res;
    endfunction

    assign rsp_valid_o    = rsp_valid_q;
    assign rsp_rs1_data_o = merge_lanes(zero1_q, fwd1_q, fwd_mask_q, fwd_data_q, rs1_q_i);
    assign rsp_rs2_data_o = merge_lanes(zero2_q, fwd2_q, fwd_mask_q, fwd_data_q, rs2_q_i);
    assign rsp_rs3_data_o = merge_lanes(zero3_q, fwd3_q, fwd_mask_q, fwd_data_q, rs3_q_i);

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // Stalled response holds, bank outputs included
    a_rsp_hold: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (rsp_valid_o && !rsp_ready_i) |=>
            (rsp_valid_o && $stable(rsp_rs1_data_o) &&
             $stable(rsp_rs2_data_o) && $stable(rsp_rs3_data_o))
    );

endmodule

`default_nettype wire

/* rtl/gpr_bank_dp.sv */
`timescale 1ns/1ps
`default_nettype none

module gpr_bank_dp (
    input  wire logic                              clk_i,
    input  wire logic                              rst_n_i,

    input  wire logic [gpr_pkg::NUM_THREADS-1:0]   wr_en_i,
    input  wire logic [gpr_pkg::RAM_AW-1:0]        wr_addr_i,
    input  wire logic [gpr_pkg::LANES_W-1:0]       wr_data_i,

    input  wire logic                              rd_en_i,
    input  wire logic [gpr_pkg::RAM_AW-1:0]        rd_addr_i,
    output logic      [gpr_pkg::LANES_W-1:0]       rd_data_o
);

    // Copy of the register file for the rs3 operand
    for (genvar i = 0; i < gpr_pkg::NUM_THREADS; i++) begin : gen_lane

        logic [gpr_pkg::XLEN-1:0] mem_q [gpr_pkg::RAM_DEPTH];
        logic [gpr_pkg::XLEN-1:0] rd_data_q;

        always_ff @(posedge clk_i) begin
            if (wr_en_i[i]) begin
                mem_q[wr_addr_i] <= wr_data_i[i*gpr_pkg::XLEN +: gpr_pkg::XLEN];
            end
        end

        always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                rd_data_q <= '0;
            end else if (rd_en_i) begin
                rd_data_q <= mem_q[rd_addr_i];
            end
        end

        assign rd_data_o[i*gpr_pkg::XLEN +: gpr_pkg::XLEN] = rd_data_q;

    end

    a_no_r0_write: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (|wr_en_i) |-> (wr_addr_i[gpr_pkg::REG_W-1:0] != '0)
    );

endmodule

`default_nettype wire

/* rtl/gpr_bank_tp.sv */
`timescale 1ns/1ps
`default_nettype none

module gpr_bank_tp (
    input  wire logic                              clk_i,
    input  wire logic                              rst_n_i,

    input  wire logic [gpr_pkg::NUM_THREADS-1:0]   wr_en_i,
    input  wire logic [gpr_pkg::RAM_AW-1:0]        wr_addr_i,
    input  wire logic [gpr_pkg::LANES_W-1:0]       wr_data_i,

    input  wire logic                              rd_en_i,
    input  wire logic [gpr_pkg::RAM_AW-1:0]        rd_addr1_i,
    input  wire logic [gpr_pkg::RAM_AW-1:0]        rd_addr2_i,
    output logic      [gpr_pkg::LANES_W-1:0]       rd_data1_o,
    output logic      [gpr_pkg::LANES_W-1:0]       rd_data2_o
);

    for (genvar i = 0; i < gpr_pkg::NUM_THREADS; i++) begin : gen_lane

        logic [gpr_pkg::XLEN-1:0] mem_q [gpr_pkg::RAM_DEPTH];
        logic [gpr_pkg::XLEN-1:0] rd_data1_q;
        logic [gpr_pkg::XLEN-1:0] rd_data2_q;

        always_ff @(posedge clk_i) begin
            if (wr_en_i[i]) begin
                mem_q[wr_addr_i] <= wr_data_i[i*gpr_pkg::XLEN +: gpr_pkg::XLEN];
            end
        end

        // Read before write, a same-edge write is not visible here
        always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                rd_data1_q <= '0;
                rd_data2_q <= '0;
            end else if (rd_en_i) begin
                rd_data1_q <= mem_q[rd_addr1_i];
                rd_data2_q <= mem_q[rd_addr2_i];
            end
        end

        assign rd_data1_o[i*gpr_pkg::XLEN +: gpr_pkg::XLEN] = rd_data1_q;
        assign rd_data2_o[i*gpr_pkg::XLEN +: gpr_pkg::XLEN] = rd_data2_q;

    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // r0 storage is never touched, the collector drops those writes
    a_no_r0_write: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (|wr_en_i) |-> (wr_addr_i[gpr_pkg::REG_W-1:0] != '0)
    );

endmodule

`default_nettype wire

/* rtl/gpr_pkg.sv */
`default_nettype none

package gpr_pkg;

    //////////////////////////////////////////////////////////////////////
    // Core organization
    //////////////////////////////////////////////////////////////////////

    // Thread lanes per warp
    localparam int unsigned NUM_THREADS = 4;

    localparam int unsigned NUM_WARPS = 4;

    // Architectural registers per warp
    localparam int unsigned NUM_REGS = 32;

    localparam int unsigned XLEN = 32;

    //////////////////////////////////////////////////////////////////////
    // Derived widths
    //////////////////////////////////////////////////////////////////////

    localparam int unsigned WID_W = $clog2(NUM_WARPS);
    localparam int unsigned REG_W = $clog2(NUM_REGS);

    // One bank entry per warp and register
    localparam int unsigned RAM_DEPTH = NUM_WARPS * NUM_REGS;

    // Warp id on top, register index below
    localparam int unsigned RAM_AW = $clog2(RAM_DEPTH);

    // Flat bus, lane i at bits i*XLEN upward
    localparam int unsigned LANES_W = NUM_THREADS * XLEN;

endpackage

`default_nettype wire
